//--- logic/ea_pkg.sv
// Shared types for the effective-address unit
// Register codes, operand mode groups, step sizes and byte selectors

package ea_pkg;

    typedef enum logic [2:0] {
        XWA,
        XBC,
        XDE,
        XHL,
        XIX,
        XIY,
        XIZ,
        XSP
    } reg_code_e;

    typedef logic [7:0]  sel_t;   // Bits 4:2 register, bits 1:0 byte
    typedef logic [23:0] addr_t;

    localparam sel_t SEL_NULL = 8'h40;  // Reads as zero

    // First-byte groups, taken from {op[6], op[3:0]}
    typedef enum logic [4:0] {
        R_SHORT  = 5'h00,  // Any first byte with bit 6 clear
        ABS8     = 5'h10,
        ABS16    = 5'h11,
        ABS24    = 5'h12,
        R32_EXT  = 5'h13,  // Plain, +d16 or +r8/r16
        PRE_DEC  = 5'h14,
        POST_INC = 5'h15
    } ea_mode_e;

    typedef enum logic [1:0] {
        STEP1 = 2'd0,
        STEP2 = 2'd1,
        STEP4 = 2'd2
    } step_e;

    function automatic sel_t full_reg_sel(reg_code_e code);
        return {3'b111, code, 2'b00};  // E0 plus four times the code
    endfunction

endpackage

//--- logic/reg_port_if.sv
// Port between the address generator and the register bank
// Index and auxiliary reads plus the step controls

`timescale 1ns/1ns

interface reg_port_if import ea_pkg::*; ();

    sel_t        idx_sel;
    logic [31:0] idx_data;   // Full register value
    sel_t        aux_sel;
    logic [15:0] aux_data;   // Zero-extended byte or halfword
    step_e       step;
    logic        inc;
    logic        dec;

    modport gen  (output idx_sel, aux_sel, step, inc, dec, input idx_data, aux_data);
    modport bank (input idx_sel, aux_sel, step, inc, dec, output idx_data, aux_data);

endinterface

//--- logic/op_window.sv
// Instruction byte window feeding the address decoder
// Appends incoming bytes and drops the bytes the decoder used

`timescale 1ns/1ns

module op_window #(
    parameter int WIN_BYTES = 8
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        cen,
    input  logic        byte_we,
    input  logic [ 7:0] byte_in,
    input  logic [ 2:0] fetched,
    output logic [31:0] op,
    output logic [ 3:0] level
);

    logic [7:0] q    [WIN_BYTES];
    logic [7:0] nx_q [WIN_BYTES];
    logic [3:0] count;
    logic [3:0] remain;
    logic [3:0] nx_count;
    logic       room;

    assign remain   = count - {1'b0, fetched};     // Bytes left after the drop
    assign room     = remain < 4'(WIN_BYTES);
    assign nx_count = remain + {3'd0, byte_we & room};

    // Shift down by fetched, then place the new byte at the tail
    always_comb begin
        for (int i = 0; i < WIN_BYTES; i++) begin
            if (i + int'(fetched) < WIN_BYTES) begin
                nx_q[i] = q[i + int'(fetched)];
            end else begin
                nx_q[i] = q[i];
            end
            if (byte_we && room && i == int'(remain)) begin
                nx_q[i] = byte_in;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count <= 4'd0;
        end else if (cen) begin
            count <= nx_count;
        end
    end

    always_ff @(posedge clk) begin
        if (cen) begin
            q <= nx_q;
        end
    end

    assign op    = {q[3], q[2], q[1], q[0]};  // Oldest byte lowest
    assign level = count;

    // Decoder may only consume what the window holds
    assert property (@(posedge clk) disable iff (rst) cen |-> {1'b0, fetched} <= level)
        else $error("op_window: fetched %0d exceeds level %0d", fetched, level);

endmodule

//--- logic/idx_addr_gen.sv
// Indexed memory-operand decoder with 24-bit address adder
// First phase picks the mode, second phase reads extension bytes

`timescale 1ns/1ns

module idx_addr_gen import ea_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        cen,
    input  logic        idx_en,
    input  logic [31:0] op,
    input  logic [ 3:0] level,
    output logic [ 2:0] fetched,
    reg_port_if.gen     rp,
    output logic        idx_ok,
    output addr_t       idx_addr
);

    ea_mode_e   mode, nx_mode;
    logic       phase, nx_phase;
    logic       pre_ok, nx_pre_ok;     // Ready flag, one cycle ahead of idx_ok
    logic       pre_inc, nx_pre_inc;   // Post-increment waits one cycle
    logic       nx_inc, nx_dec;
    logic       use_aux, nx_use_aux;   // Index register form
    logic       aux_wide, nx_aux_wide; // r16 instead of r8
    step_e      nx_step;
    sel_t       nx_idx_sel, nx_aux_sel;
    addr_t      offset, nx_offset;
    addr_t      aux_ext, nx_addr;
    addr_t      step_amt, idx_base;
    logic [4:0] raw_mode;

    assign raw_mode = {op[6], op[3:0]};
    assign aux_ext  = aux_wide ? {{8{rp.aux_data[15]}}, rp.aux_data}
                               : {{16{rp.aux_data[7]}}, rp.aux_data[7:0]};

    // Step size in bytes
    always_comb begin
        case (rp.step)
            STEP2:   step_amt = 24'd2;
            STEP4:   step_amt = 24'd4;
            default: step_amt = 24'd1;
        endcase
    end

    // Bank applies a pending decrement on this same edge
    assign idx_base = rp.dec ? rp.idx_data[23:0] - step_amt : rp.idx_data[23:0];

    // Tracks the register until idx_ok
    assign nx_addr = (idx_en && !idx_ok) ?
                     idx_base + (use_aux ? aux_ext : offset) : idx_addr;

    always_comb begin
        fetched     = 3'd0;
        nx_mode     = mode;
        nx_phase    = 1'b0;
        nx_pre_ok   = pre_ok & idx_en;
        nx_pre_inc  = 1'b0;
        nx_inc      = pre_inc;
        nx_dec      = 1'b0;
        nx_use_aux  = use_aux;
        nx_aux_wide = aux_wide;
        nx_step     = rp.step;
        nx_idx_sel  = rp.idx_sel;
        nx_aux_sel  = rp.aux_sel;
        nx_offset   = offset;
        if (idx_en && !pre_ok) begin
            if (!phase) begin
                fetched    = 3'd2;
                nx_use_aux = 1'b0;
                nx_offset  = '0;
                if (!op[6]) begin
                    nx_mode    = R_SHORT;
                    nx_idx_sel = full_reg_sel(reg_code_e'(op[2:0]));
                    nx_offset  = op[3] ? {{16{op[15]}}, op[15:8]} : '0;  // Optional d8
                    fetched    = op[3] ? 3'd2 : 3'd1;
                    nx_pre_ok  = 1'b1;
                end else begin
                    case (raw_mode)
                        ABS8, ABS16, ABS24: begin
                            nx_mode    = ea_mode_e'(raw_mode);
                            nx_idx_sel = SEL_NULL;
                            nx_offset  = {16'd0, op[15:8]};   // Low address byte
                            nx_pre_ok  = raw_mode == ABS8;
                            nx_phase   = raw_mode != ABS8;
                        end
                        R32_EXT: begin
                            nx_mode    = R32_EXT;
                            nx_idx_sel = {op[15:10], 2'd0};
                            case (op[9:8])
                                2'd1: nx_phase = 1'b1;       // d16 follows
                                2'd2: begin
                                    nx_phase    = 1'b1;      // Register pair follows
                                    nx_use_aux  = 1'b1;
                                    nx_aux_wide = op[10];
                                end
                                default: nx_pre_ok = 1'b1;
                            endcase
                        end
                        PRE_DEC, POST_INC: begin
                            nx_mode    = ea_mode_e'(raw_mode);
                            nx_idx_sel = {op[15:10], 2'd0};
                            nx_step    = step_e'(op[9:8]);
                            nx_dec     = raw_mode == PRE_DEC;
                            nx_pre_inc = raw_mode == POST_INC;
                            nx_pre_ok  = 1'b1;
                        end
                        default: begin
                            nx_idx_sel = SEL_NULL;           // Unknown group skips its byte
                            fetched    = 3'd1;
                            nx_pre_ok  = 1'b1;
                        end
                    endcase
                end
            end else begin
                nx_pre_ok = 1'b1;
                case (mode)
                    ABS16: begin
                        nx_offset[23:8] = {8'd0, op[7:0]};
                        fetched         = 3'd1;
                    end
                    ABS24: begin
                        nx_offset[23:8] = op[15:0];
                        fetched         = 3'd2;
                    end
                    R32_EXT: begin
                        fetched = 3'd2;
                        if (use_aux) begin
                            nx_idx_sel = op[7:0];
                            nx_aux_sel = op[15:8];
                        end else begin
                            nx_offset = {{8{op[15]}}, op[15:0]};
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mode     <= R_SHORT;
            phase    <= 1'b0;
            pre_ok   <= 1'b0;
            pre_inc  <= 1'b0;
            use_aux  <= 1'b0;
            aux_wide <= 1'b0;
            rp.inc   <= 1'b0;
            rp.dec   <= 1'b0;
            idx_ok   <= 1'b0;
        end else if (cen) begin
            mode     <= nx_mode;
            phase    <= nx_phase;
            pre_ok   <= nx_pre_ok;
            pre_inc  <= nx_pre_inc;
            use_aux  <= nx_use_aux;
            aux_wide <= nx_aux_wide;
            rp.inc   <= nx_inc;
            rp.dec   <= nx_dec;
            idx_ok   <= pre_ok;
        end
    end

    always_ff @(posedge clk) begin
        if (cen) begin
            offset     <= nx_offset;
            rp.idx_sel <= nx_idx_sel;
            rp.aux_sel <= nx_aux_sel;
            rp.step    <= nx_step;
            idx_addr   <= nx_addr;
        end
    end

    // A new operand needs four bytes in the window
    assert property (@(posedge clk) disable iff (rst)
                     cen && idx_en && !pre_ok && !phase |-> level >= 4'd4)
        else $error("idx_addr_gen: idx_en with level %0d", level);

endmodule

//--- logic/reg_bank.sv
// Eight 32-bit registers XWA to XSP
// Index and auxiliary reads, host port and step increment or decrement

`timescale 1ns/1ns

module reg_bank import ea_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        cen,
    reg_port_if.bank    rp,
    input  logic        wr_en,
    input  reg_code_e   wr_sel,
    input  logic [31:0] wr_data,
    input  reg_code_e   rd_sel,
    output logic [31:0] rd_data
);

    logic [31:0] regs [8];
    logic [31:0] aux_word;
    logic [31:0] step_val;
    logic [ 2:0] idx_reg;

    assign idx_reg  = rp.idx_sel[4:2];       // Low selectors wrap modulo 32
    assign aux_word = regs[rp.aux_sel[4:2]];

    always_comb begin
        case (rp.step)
            STEP2:   step_val = 32'd2;
            STEP4:   step_val = 32'd4;
            default: step_val = 32'd1;
        endcase
    end

    assign rp.idx_data = (rp.idx_sel == SEL_NULL) ? 32'd0 : regs[idx_reg];

    always_comb begin
        if (rp.aux_sel == SEL_NULL) begin
            rp.aux_data = 16'd0;
        end else begin
            case (rp.aux_sel[1:0])
                2'd0:    rp.aux_data = aux_word[15:0];
                2'd1:    rp.aux_data = {8'd0, aux_word[15:8]};
                2'd2:    rp.aux_data = aux_word[31:16];
                default: rp.aux_data = {8'd0, aux_word[31:24]};
            endcase
        end
    end

    assign rd_data = regs[rd_sel];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= 32'd0;
            end
        end else if (cen) begin
            if (wr_en) begin
                regs[wr_sel] <= wr_data;                     // Host wins over a step
            end else if (rp.inc && rp.idx_sel != SEL_NULL) begin
                regs[idx_reg] <= regs[idx_reg] + step_val;
            end else if (rp.dec && rp.idx_sel != SEL_NULL) begin
                regs[idx_reg] <= regs[idx_reg] - step_val;
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst) !(rp.inc && rp.dec))
        else $error("reg_bank: inc and dec both high");

endmodule

//--- logic/ea_issue.sv
// Request stage for finished addresses
// One ea_valid pulse per rising idx_ok, address held until the next

`timescale 1ns/1ns

module ea_issue import ea_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  cen,
    input  logic  idx_ok,
    input  addr_t idx_addr,
    output logic  ea_valid,
    output addr_t ea_addr
);

    logic idx_ok_d;
    logic ok_rise;

    assign ok_rise = idx_ok & ~idx_ok_d;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            idx_ok_d <= 1'b0;
            ea_valid <= 1'b0;
        end else if (cen) begin
            idx_ok_d <= idx_ok;
            ea_valid <= ok_rise;
        end
    end

    always_ff @(posedge clk) begin
        if (cen && ok_rise) begin
            ea_addr <= idx_addr;   // Captured with the pulse
        end
    end

endmodule

//--- logic/ea_unit_top.sv
// Effective-address unit top level
// Byte window, address generator, register bank and request stage

`timescale 1ns/1ns

module ea_unit_top import ea_pkg::*; #(
    parameter int WIN_BYTES = 8
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        cen,
    input  logic        byte_we,
    input  logic [ 7:0] byte_in,
    input  logic        idx_en,
    input  logic        wr_en,
    input  reg_code_e   wr_sel,
    input  logic [31:0] wr_data,
    input  reg_code_e   rd_sel,
    output logic [31:0] rd_data,
    output logic [ 3:0] level,
    output logic        ea_valid,
    output addr_t       ea_addr
);

    logic [31:0] op;
    logic [ 2:0] fetched;
    logic        idx_ok;
    addr_t       idx_addr;

    reg_port_if rp ();

    op_window #(
        .WIN_BYTES(WIN_BYTES)
    ) u_window (
        .clk     (clk),
        .rst     (rst),
        .cen     (cen),
        .byte_we (byte_we),
        .byte_in (byte_in),
        .fetched (fetched),
        .op      (op),
        .level   (level)
    );

    idx_addr_gen u_gen (
        .clk      (clk),
        .rst      (rst),
        .cen      (cen),
        .idx_en   (idx_en),
        .op       (op),
        .level    (level),
        .fetched  (fetched),
        .rp       (rp.gen),
        .idx_ok   (idx_ok),
        .idx_addr (idx_addr)
    );

    reg_bank u_bank (
        .clk     (clk),
        .rst     (rst),
        .cen     (cen),
        .rp      (rp.bank),
        .wr_en   (wr_en),
        .wr_sel  (wr_sel),
        .wr_data (wr_data),
        .rd_sel  (rd_sel),
        .rd_data (rd_data)
    );

    ea_issue u_issue (
        .clk      (clk),
        .rst      (rst),
        .cen      (cen),
        .idx_ok   (idx_ok),
        .idx_addr (idx_addr),
        .ea_valid (ea_valid),
        .ea_addr  (ea_addr)
    );

endmodule

//--- dv/ea_unit_tb.sv
// Directed testbench for the effective-address unit
// Clock, reset, stimulus tasks, compare tasks and the test sequence

`timescale 1ns/1ns

module ea_unit_tb import ea_pkg::*; ();

    logic        clk;
    logic        rst;
    logic        cen;
    logic        byte_we;
    logic [ 7:0] byte_in;
    logic        idx_en;
    logic        wr_en;
    reg_code_e   wr_sel;
    logic [31:0] wr_data;
    reg_code_e   rd_sel;
    logic [31:0] rd_data;
    logic [ 3:0] level;
    logic        ea_valid;
    addr_t       ea_addr;

    int          errors;
    int          checks;
    int          tests;
    int          test_start;
    logic [15:0] lfsr;

    ea_unit_top #(
        .WIN_BYTES(8)
    ) DUT (
        .clk      (clk),
        .rst      (rst),
        .cen      (cen),
        .byte_we  (byte_we),
        .byte_in  (byte_in),
        .idx_en   (idx_en),
        .wr_en    (wr_en),
        .wr_sel   (wr_sel),
        .wr_data  (wr_data),
        .rd_sel   (rd_sel),
        .rd_data  (rd_data),
        .level    (level),
        .ea_valid (ea_valid),
        .ea_addr  (ea_addr)
    );

    always #2 clk = ~clk;  // 4 ns period

    // Taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_next(logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);           // One step per bit
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic addr_t sext8(logic [7:0] d);
        return {{16{d[7]}}, d};
    endfunction

    function automatic addr_t sext16(logic [15:0] d);
        return {{8{d[15]}}, d};
    endfunction

    task automatic tick();
        @(posedge clk);
        #1;                                   // Drive and sample after the edge
    endtask

    task automatic reset_dut();
        rst = 1'b1;
        repeat (4) tick();
        rst = 1'b0;
    endtask

    task automatic load_reg(reg_code_e code, logic [31:0] value);
        wr_en   = 1'b1;
        wr_sel  = code;
        wr_data = value;
        tick();
        wr_en   = 1'b0;
    endtask

    task automatic read_reg(reg_code_e code, output logic [31:0] value);
        rd_sel = code;
        tick();
        value  = rd_data;
    endtask

    // Oldest byte in bits 7:0
    task automatic push_bytes(logic [31:0] bytes, int n);
        for (int i = 0; i < n; i++) begin
            byte_we = 1'b1;
            byte_in = bytes[8*i +: 8];
            tick();
        end
        byte_we = 1'b0;
    endtask

    task automatic run_ea(output addr_t addr);
        int   cycles;
        logic seen;
        idx_en = 1'b1;
        seen   = 1'b0;
        cycles = 0;
        addr   = '0;
        while (!seen && cycles < 20) begin
            tick();
            cycles++;
            seen = ea_valid;
        end
        idx_en = 1'b0;                        // Dropped on the pulse
        checks++;
        if (!seen) begin
            $display("Timeout at %0t ns: no ea_valid pulse within 20 cycles", $time);
            errors++;
        end else begin
            addr = ea_addr;
            tick();
            if (ea_valid) begin
                $display("At %0t ns ea_valid stayed high for a second cycle", $time);
                errors++;
            end
        end
    endtask

    task automatic check_addr(string what, addr_t got, addr_t exp);
        checks++;
        if (got !== exp) begin
            $display("Error at %0t ns: ea_addr (%s) got %h expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_reg(reg_code_e code, logic [31:0] got, logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("Error at %0t ns: rd_data %s got %h expected %h",
                     $time, code.name(), got, exp);
            errors++;
        end
    endtask

    task automatic check_level(logic [3:0] got, logic [3:0] exp);
        checks++;
        if (got !== exp) begin
            $display("Error at %0t ns: level got %0d expected %0d", $time, got, exp);
            errors++;
        end
    endtask

    // Four bytes keep the window deep enough to start a request
    task automatic decode_one(string what, logic [31:0] bytes, addr_t exp_addr,
                              logic [3:0] exp_level);
        addr_t got;
        push_bytes(bytes, 4);
        run_ea(got);
        check_addr(what, got, exp_addr);
        check_level(level, exp_level);
    endtask

    task automatic finish_test(string name);
        tests++;
        if (errors == test_start) begin
            $display("test %-14s ok", name);
        end else begin
            $display("test %-14s %0d errors", name, errors - test_start);
        end
    endtask

    task automatic test_short();
        logic [31:0] v;
        logic [ 7:0] d8;
        reg_code_e   code;
        test_start = errors;
        for (int c = 0; c < 8; c++) begin
            code = reg_code_e'(3'(c));
            v    = rand_bits(32);
            d8   = 8'(rand_bits(8));
            reset_dut();
            load_reg(code, v);
            decode_one("short", {24'd0, 5'b00000, 3'(c)}, v[23:0], 4'd3);
            reset_dut();
            load_reg(code, v);
            decode_one("short d8", {16'd0, d8, 5'b00001, 3'(c)}, v[23:0] + sext8(d8), 4'd2);
        end
        finish_test("short");
    endtask

    task automatic test_absolute();
        addr_t a;
        test_start = errors;
        for (int i = 0; i < 2; i++) begin
            a = addr_t'(rand_bits(24));
            reset_dut();
            decode_one("abs8", {16'd0, a[7:0], 8'h40}, {16'd0, a[7:0]}, 4'd2);
            reset_dut();
            decode_one("abs16", {8'd0, a[15:0], 8'h41}, {8'd0, a[15:0]}, 4'd1);
            reset_dut();
            decode_one("abs24", {a, 8'h42}, a, 4'd0);
        end
        finish_test("absolute");
    endtask

    task automatic test_reg32();
        reg_code_e   base;
        reg_code_e   aux;
        logic [31:0] vb;
        logic [31:0] va;
        logic [15:0] d16;
        logic [15:0] half;
        logic [ 1:0] k;
        logic        h;
        test_start = errors;
        for (int i = 0; i < 4; i++) begin
            base = reg_code_e'(3'(rand_bits(3)));
            aux  = reg_code_e'(3'(base) ^ 3'd1);  // Second register differs from base
            vb   = rand_bits(32);
            va   = rand_bits(32);
            d16  = 16'(rand_bits(16));
            k    = 2'(rand_bits(2));
            h    = rand_bits(1) != 0;
            half = h ? va[31:16] : va[15:0];
            reset_dut();
            load_reg(base, vb);
            decode_one("r32", {16'd0, full_reg_sel(base), 8'h43}, vb[23:0], 4'd2);
            reset_dut();
            load_reg(base, vb);
            decode_one("r32 d16", {d16, full_reg_sel(base) | 8'h01, 8'h43},
                       vb[23:0] + sext16(d16), 4'd0);
            reset_dut();
            load_reg(base, vb);
            load_reg(aux, va);
            decode_one("r32 r8", {full_reg_sel(aux) | {6'd0, k}, full_reg_sel(base), 8'hE2,
                       8'h43}, vb[23:0] + sext8(va[8*k +: 8]), 4'd0);
            reset_dut();
            load_reg(base, vb);
            load_reg(aux, va);
            decode_one("r32 r16", {full_reg_sel(aux) | {6'd0, h, 1'b0}, full_reg_sel(base),
                       8'hE6, 8'h43}, vb[23:0] + sext16(half), 4'd0);
        end
        finish_test("reg32");
    endtask

    task automatic test_step();
        reg_code_e   code;
        logic [31:0] v;
        logic [31:0] size;
        logic [31:0] exp_v;
        logic [31:0] got;
        test_start = errors;
        for (int s = 0; s < 3; s++) begin
            for (int post = 0; post < 2; post++) begin
                code  = reg_code_e'(3'(rand_bits(3)));
                v     = rand_bits(32);
                size  = 32'd1 << s;               // Encodings 0, 1, 2 step 1, 2, 4
                exp_v = post != 0 ? v + size : v - size;
                reset_dut();
                load_reg(code, v);
                // Pre-decrement addresses the new value, post-increment the old one
                decode_one(post != 0 ? "post inc" : "pre dec",
                           {16'd0, full_reg_sel(code) | 8'(s), post != 0 ? 8'h45 : 8'h44},
                           post != 0 ? v[23:0] : exp_v[23:0], 4'd2);
                read_reg(code, got);
                check_reg(code, got, exp_v);
            end
        end
        finish_test("step");
    endtask

    task automatic test_back_to_back();
        logic [31:0] vd;
        logic [31:0] vh;
        logic [ 7:0] d8;
        logic [ 7:0] a8;
        addr_t       got;
        test_start = errors;
        vd = rand_bits(32);
        vh = rand_bits(32);
        d8 = 8'(rand_bits(8));
        a8 = 8'(rand_bits(8));
        reset_dut();
        load_reg(XDE, vd);
        load_reg(XHL, vh);
        push_bytes({a8, 8'h40, d8, 8'h0A}, 4);    // XDE+d8, then abs8
        push_bytes({24'd0, 8'h03}, 4);            // XHL, then three spare bytes
        run_ea(got);
        check_addr("b2b d8", got, vd[23:0] + sext8(d8));
        check_level(level, 4'd6);
        run_ea(got);
        check_addr("b2b abs8", got, {16'd0, a8});
        check_level(level, 4'd4);
        run_ea(got);
        check_addr("b2b short", got, vh[23:0]);
        check_level(level, 4'd3);
        finish_test("back to back");
    endtask

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        cen        = 1'b1;
        byte_we    = 1'b0;
        byte_in    = 8'd0;
        idx_en     = 1'b0;
        wr_en      = 1'b0;
        wr_sel     = XWA;
        wr_data    = 32'd0;
        rd_sel     = XWA;
        errors     = 0;
        checks     = 0;
        tests      = 0;
        test_start = 0;
        lfsr       = 16'd8;
        reset_dut();
        test_short();
        test_absolute();
        test_reg32();
        test_step();
        test_back_to_back();
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- sim.f
logic/ea_pkg.sv
logic/reg_port_if.sv
logic/op_window.sv
logic/idx_addr_gen.sv
logic/reg_bank.sv
logic/ea_issue.sv
logic/ea_unit_top.sv
dv/ea_unit_tb.sv

//--- Makefile
# Verilator build for the effective-address unit testbench

VERILATOR ?= verilator
TOP       ?= ea_unit_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns
PASS_MSG  ?= *** TEST PASSED ***

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
